// ==== include/mem_macros.svh ====
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// byte address width.
`define MEM_ADDR_W 32

// data width, one word per access.
`define MEM_DATA_W 32

// log2 of the word count, 1024 words gives 4 KiB.
`define MEM_DEPTH_LOG2 10

// nonzero start value for the delay lfsr.
`define LFSR_SEED 8'hA5

`endif

// ==== design/mem_pkg.sv ====
package mem_pkg;

  // read channel FSM.
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT,
    RD_RESP
  } rd_state_e;

  // write channel FSM, address and data may land together.
  typedef enum logic [1:0] {
    WR_ADDR,
    WR_DATA,
    WR_WAIT,
    WR_RESP
  } wr_state_e;

  typedef enum logic {
    RESP_OKAY   = 1'b0,
    RESP_SLVERR = 1'b1
  } resp_e;

  typedef enum logic {
    REQ_IFU,  // instruction fetch.
    REQ_LSU   // load/store.
  } req_e;

endpackage

// ==== design/axi_lite_if.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

interface axi_lite_if;

  // read address.
  logic [`MEM_ADDR_W-1:0]   araddr;
  logic                     arvalid;
  logic                     arready;

  // read data.
  logic [`MEM_DATA_W-1:0]   rdata;
  mem_pkg::resp_e           rresp;
  logic                     rvalid;
  logic                     rready;

  // write address.
  logic [`MEM_ADDR_W-1:0]   awaddr;
  logic                     awvalid;
  logic                     awready;

  // write data, one strobe per byte.
  logic [`MEM_DATA_W-1:0]   wdata;
  logic [`MEM_DATA_W/8-1:0] wstrb;
  logic                     wvalid;
  logic                     wready;

  // write response.
  mem_pkg::resp_e           bresp;
  logic                     bvalid;
  logic                     bready;

  modport master (
    output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
  );

  modport slave (
    input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
  );

endinterface

// ==== design/delay_lfsr.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module delay_lfsr (
  input  logic       clk,
  input  logic       rst,
  output logic [7:0] value
);

  logic [7:0] state_q;
  logic       feedback;

  // taps 8, 6, 5, 4 give the full 255 state cycle.
  assign feedback = state_q[7] ^ state_q[5] ^ state_q[4] ^ state_q[3];

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= `LFSR_SEED;
    end else begin
      state_q <= {state_q[6:0], feedback};
    end
  end

  assign value = state_q;

endmodule

// ==== design/axi_sram.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module axi_sram (
  input logic       clk,
  input logic       rst,
  axi_lite_if.slave bus
);

  localparam int WORDS  = 1 << `MEM_DEPTH_LOG2;
  localparam int STRB_W = `MEM_DATA_W / 8;

  logic [`MEM_DATA_W-1:0] mem [WORDS];

  mem_pkg::rd_state_e     rd_state;
  mem_pkg::wr_state_e     wr_state;
  logic [2:0]             rd_cnt;
  logic [2:0]             wr_cnt;
  logic [7:0]             lfsr_value;

  logic [`MEM_ADDR_W-1:0] ar_addr_q;
  logic [`MEM_ADDR_W-1:0] aw_addr_q;
  logic [`MEM_DATA_W-1:0] w_data_q;
  logic [STRB_W-1:0]      w_strb_q;

  logic ar_fire;
  logic aw_fire;
  logic w_fire;
  logic rd_done;
  logic wr_done;

  function automatic logic in_range(input logic [`MEM_ADDR_W-1:0] addr);
    return addr[`MEM_ADDR_W-1:`MEM_DEPTH_LOG2+2] == '0;
  endfunction

  delay_lfsr i_delay_lfsr (
    .clk   (clk),
    .rst   (rst),
    .value (lfsr_value)
  );

  assign ar_fire = bus.arvalid && bus.arready;
  assign aw_fire = bus.awvalid && bus.awready;
  assign w_fire  = bus.wvalid && bus.wready;
  assign rd_done = (rd_state == mem_pkg::RD_WAIT) && (rd_cnt == 3'd0);
  assign wr_done = (wr_state == mem_pkg::WR_WAIT) && (wr_cnt == 3'd0);

  // ====================================================================
  // read FSM
  // ====================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state    <= mem_pkg::RD_IDLE;
      rd_cnt      <= 3'd0;
      bus.arready <= 1'b1;
      bus.rvalid  <= 1'b0;
    end else begin
      case (rd_state)
        mem_pkg::RD_IDLE: if (ar_fire) begin
          bus.arready <= 1'b0;
          rd_cnt      <= lfsr_value[2:0];  // 0..7 wait cycles.
          rd_state    <= mem_pkg::RD_WAIT;
        end
        mem_pkg::RD_WAIT: if (rd_cnt == 3'd0) begin
          bus.rvalid <= 1'b1;
          rd_state   <= mem_pkg::RD_RESP;
        end else begin
          rd_cnt <= rd_cnt - 3'd1;
        end
        mem_pkg::RD_RESP: if (bus.rready) begin
          bus.rvalid  <= 1'b0;
          bus.arready <= 1'b1;
          rd_state    <= mem_pkg::RD_IDLE;
        end
        default: rd_state <= mem_pkg::RD_IDLE;
      endcase
    end
  end

  // ====================================================================
  // write FSM
  // ====================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state    <= mem_pkg::WR_ADDR;
      wr_cnt      <= 3'd0;
      bus.awready <= 1'b1;
      bus.wready  <= 1'b1;
      bus.bvalid  <= 1'b0;
    end else begin
      case (wr_state)
        mem_pkg::WR_ADDR: begin
          if (w_fire) bus.wready <= 1'b0;  // data may come first.
          if (aw_fire) begin
            bus.awready <= 1'b0;
            if (w_fire || !bus.wready) begin
              wr_cnt   <= lfsr_value[2:0];
              wr_state <= mem_pkg::WR_WAIT;
            end else begin
              wr_state <= mem_pkg::WR_DATA;
            end
          end
        end
        mem_pkg::WR_DATA: if (w_fire) begin
          bus.wready <= 1'b0;
          wr_cnt     <= lfsr_value[2:0];
          wr_state   <= mem_pkg::WR_WAIT;
        end
        mem_pkg::WR_WAIT: if (wr_cnt == 3'd0) begin
          bus.bvalid <= 1'b1;
          wr_state   <= mem_pkg::WR_RESP;
        end else begin
          wr_cnt <= wr_cnt - 3'd1;
        end
        mem_pkg::WR_RESP: if (bus.bready) begin
          bus.bvalid  <= 1'b0;
          bus.awready <= 1'b1;
          bus.wready  <= 1'b1;
          wr_state    <= mem_pkg::WR_ADDR;
        end
      endcase
    end
  end

  // ====================================================================
  // datapath and array
  // ====================================================================
  always_ff @(posedge clk) begin
    if (ar_fire) ar_addr_q <= bus.araddr;
    if (aw_fire) aw_addr_q <= bus.awaddr;
    if (w_fire) begin
      w_data_q <= bus.wdata;
      w_strb_q <= bus.wstrb;
    end

    if (rd_done) begin
      if (in_range(ar_addr_q)) begin
        bus.rdata <= mem[ar_addr_q[`MEM_DEPTH_LOG2+1:2]];
        bus.rresp <= mem_pkg::RESP_OKAY;
      end else begin
        bus.rdata <= '0;
        bus.rresp <= mem_pkg::RESP_SLVERR;
      end
    end

    if (wr_done) begin
      if (in_range(aw_addr_q)) begin
        bus.bresp <= mem_pkg::RESP_OKAY;
        for (int i = 0; i < STRB_W; i++) begin
          if (w_strb_q[i]) mem[aw_addr_q[`MEM_DEPTH_LOG2+1:2]][8*i +: 8] <= w_data_q[8*i +: 8];
        end
      end else begin
        bus.bresp <= mem_pkg::RESP_SLVERR;  // write dropped.
      end
    end
  end

endmodule

// ==== design/axi_arbiter.sv ====
`timescale 1ns/1ps

module axi_arbiter (
  input logic        clk,
  input logic        rst,
  axi_lite_if.slave  ifu,
  axi_lite_if.slave  lsu,
  axi_lite_if.master mem
);

  mem_pkg::req_e owner_q;  // holds the read path until R completes.
  mem_pkg::req_e last_q;   // winner of the last contended grant.
  mem_pkg::req_e grant;
  mem_pkg::req_e sel;
  logic          busy_q;
  logic          contend;
  logic          ar_fire;
  logic          r_fire;

  // ====================================================================
  // read grant
  // ====================================================================
  always_comb begin
    contend = ifu.arvalid && lsu.arvalid;
    if (contend) begin
      grant = (last_q == mem_pkg::REQ_IFU) ? mem_pkg::REQ_LSU : mem_pkg::REQ_IFU;
    end else if (lsu.arvalid) begin
      grant = mem_pkg::REQ_LSU;
    end else begin
      grant = mem_pkg::REQ_IFU;
    end
  end

  assign sel     = busy_q ? owner_q : grant;
  assign ar_fire = mem.arvalid && mem.arready;
  assign r_fire  = mem.rvalid && mem.rready;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q  <= 1'b0;
      owner_q <= mem_pkg::REQ_IFU;
      last_q  <= mem_pkg::REQ_LSU;  // ifu wins the first tie.
    end else begin
      if (ar_fire) begin
        busy_q  <= 1'b1;
        owner_q <= sel;
        if (contend) last_q <= sel;
      end
      if (r_fire) busy_q <= 1'b0;
    end
  end

  // ====================================================================
  // read routing
  // ====================================================================
  assign mem.araddr  = (sel == mem_pkg::REQ_LSU) ? lsu.araddr : ifu.araddr;
  assign mem.arvalid = !busy_q &&
                       ((sel == mem_pkg::REQ_LSU) ? lsu.arvalid : ifu.arvalid);

  // an idle port sees ready, a losing requester does not.
  assign ifu.arready = !busy_q && mem.arready &&
                       ((sel == mem_pkg::REQ_IFU) || !ifu.arvalid);
  assign lsu.arready = !busy_q && mem.arready &&
                       ((sel == mem_pkg::REQ_LSU) || !lsu.arvalid);

  assign mem.rready = (owner_q == mem_pkg::REQ_LSU) ? lsu.rready : ifu.rready;
  assign ifu.rvalid = mem.rvalid && (owner_q == mem_pkg::REQ_IFU);
  assign lsu.rvalid = mem.rvalid && (owner_q == mem_pkg::REQ_LSU);
  assign ifu.rdata  = mem.rdata;
  assign ifu.rresp  = mem.rresp;
  assign lsu.rdata  = mem.rdata;
  assign lsu.rresp  = mem.rresp;

  // ====================================================================
  // write routing, load/store only
  // ====================================================================
  assign mem.awaddr  = lsu.awaddr;
  assign mem.awvalid = lsu.awvalid;
  assign lsu.awready = mem.awready;
  assign mem.wdata   = lsu.wdata;
  assign mem.wstrb   = lsu.wstrb;
  assign mem.wvalid  = lsu.wvalid;
  assign lsu.wready  = mem.wready;
  assign lsu.bresp   = mem.bresp;
  assign lsu.bvalid  = mem.bvalid;
  assign mem.bready  = lsu.bready;

  // fetch side never writes.
  assign ifu.awready = 1'b0;
  assign ifu.wready  = 1'b0;
  assign ifu.bvalid  = 1'b0;
  assign ifu.bresp   = mem_pkg::RESP_OKAY;

endmodule

// ==== design/mem_subsys.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_subsys (
  input  logic                     clk,
  input  logic                     rst,

  // instruction fetch, read only.
  input  logic [`MEM_ADDR_W-1:0]   ifu_araddr,
  input  logic                     ifu_arvalid,
  output logic                     ifu_arready,
  output logic [`MEM_DATA_W-1:0]   ifu_rdata,
  output mem_pkg::resp_e           ifu_rresp,
  output logic                     ifu_rvalid,
  input  logic                     ifu_rready,

  // load/store.
  input  logic [`MEM_ADDR_W-1:0]   lsu_araddr,
  input  logic                     lsu_arvalid,
  output logic                     lsu_arready,
  output logic [`MEM_DATA_W-1:0]   lsu_rdata,
  output mem_pkg::resp_e           lsu_rresp,
  output logic                     lsu_rvalid,
  input  logic                     lsu_rready,
  input  logic [`MEM_ADDR_W-1:0]   lsu_awaddr,
  input  logic                     lsu_awvalid,
  output logic                     lsu_awready,
  input  logic [`MEM_DATA_W-1:0]   lsu_wdata,
  input  logic [`MEM_DATA_W/8-1:0] lsu_wstrb,
  input  logic                     lsu_wvalid,
  output logic                     lsu_wready,
  output mem_pkg::resp_e           lsu_bresp,
  output logic                     lsu_bvalid,
  input  logic                     lsu_bready
);

  axi_lite_if ifu_bus ();
  axi_lite_if lsu_bus ();
  axi_lite_if mem_bus ();

  // ====================================================================
  // requester ports onto the buses
  // ====================================================================
  assign ifu_bus.araddr  = ifu_araddr;
  assign ifu_bus.arvalid = ifu_arvalid;
  assign ifu_arready     = ifu_bus.arready;
  assign ifu_rdata       = ifu_bus.rdata;
  assign ifu_rresp       = ifu_bus.rresp;
  assign ifu_rvalid      = ifu_bus.rvalid;
  assign ifu_bus.rready  = ifu_rready;

  // fetch write channel held idle.
  assign ifu_bus.awaddr  = '0;
  assign ifu_bus.awvalid = 1'b0;
  assign ifu_bus.wdata   = '0;
  assign ifu_bus.wstrb   = '0;
  assign ifu_bus.wvalid  = 1'b0;
  assign ifu_bus.bready  = 1'b0;

  assign lsu_bus.araddr  = lsu_araddr;
  assign lsu_bus.arvalid = lsu_arvalid;
  assign lsu_arready     = lsu_bus.arready;
  assign lsu_rdata       = lsu_bus.rdata;
  assign lsu_rresp       = lsu_bus.rresp;
  assign lsu_rvalid      = lsu_bus.rvalid;
  assign lsu_bus.rready  = lsu_rready;
  assign lsu_bus.awaddr  = lsu_awaddr;
  assign lsu_bus.awvalid = lsu_awvalid;
  assign lsu_awready     = lsu_bus.awready;
  assign lsu_bus.wdata   = lsu_wdata;
  assign lsu_bus.wstrb   = lsu_wstrb;
  assign lsu_bus.wvalid  = lsu_wvalid;
  assign lsu_wready      = lsu_bus.wready;
  assign lsu_bresp       = lsu_bus.bresp;
  assign lsu_bvalid      = lsu_bus.bvalid;
  assign lsu_bus.bready  = lsu_bready;

  axi_arbiter i_axi_arbiter (
    .clk (clk),
    .rst (rst),
    .ifu (ifu_bus.slave),
    .lsu (lsu_bus.slave),
    .mem (mem_bus.master)
  );

  axi_sram i_axi_sram (
    .clk (clk),
    .rst (rst),
    .bus (mem_bus.slave)
  );

endmodule

// ==== test/mem_subsys_props.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_subsys_props (
  input logic                   clk,
  input logic                   rst,
  input logic                   arready,
  input logic [`MEM_DATA_W-1:0] rdata,
  input logic                   rvalid,
  input logic                   rready,
  input logic                   bvalid,
  input logic                   bready
);

  // read response is held, data too, until taken.
  rdata_hold: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("rvalid dropped or rdata changed before rready");

  bvalid_hold: assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  // one read in flight.
  ar_blocked: assert property (@(posedge clk) disable iff (rst)
    rvalid |-> !arready)
    else $error("arready high while rvalid is high");

  reset_clear: assert property (@(posedge clk)
    rst |=> !rvalid && !bvalid)
    else $error("response valid high in the cycle after reset");

endmodule

bind axi_sram mem_subsys_props i_mem_subsys_props (
  .clk     (clk),
  .rst     (rst),
  .arready (bus.arready),
  .rdata   (bus.rdata),
  .rvalid  (bus.rvalid),
  .rready  (bus.rready),
  .bvalid  (bus.bvalid),
  .bready  (bus.bready)
);

// ==== test/mem_subsys_tb.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_subsys_tb;

  localparam int          CLK_PERIOD     = 20;
  localparam int          TIMEOUT_CYCLES = 20000;  // about 4x the longest run.
  localparam logic [31:0] SEED           = 32'd86;
  localparam int          MEM_BYTES      = 4 << `MEM_DEPTH_LOG2;
  localparam bit          IFU            = 1'b0;
  localparam bit          LSU            = 1'b1;

  logic clk;
  logic rst;

  // index 0 is fetch, 1 is load/store.
  logic [1:0][`MEM_ADDR_W-1:0] araddr;
  logic [1:0]                  arvalid;
  logic [1:0]                  rready;
  wire  [1:0]                  arready;
  wire  [1:0][`MEM_DATA_W-1:0] rdata;
  wire  [1:0]                  rresp;
  wire  [1:0]                  rvalid;

  logic [`MEM_ADDR_W-1:0]   awaddr;
  logic                     awvalid;
  logic [`MEM_DATA_W-1:0]   wdata;
  logic [`MEM_DATA_W/8-1:0] wstrb;
  logic                     wvalid;
  logic                     bready;
  wire                      awready;
  wire                      wready;
  wire                      bresp;
  wire                      bvalid;

  logic [7:0]  model [MEM_BYTES];  // byte-wide reference memory.
  logic [31:0] rng_state;
  logic [1:0]  rvalid_q;
  logic        bvalid_q;
  int          r_at [2];
  int          cycles;
  int          r_seen;
  int          b_seen;
  int          reads_issued;
  int          writes_issued;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_bad;

  mem_subsys i_mem_subsys (
    .clk         (clk),
    .rst         (rst),
    .ifu_araddr  (araddr[IFU]),
    .ifu_arvalid (arvalid[IFU]),
    .ifu_arready (arready[IFU]),
    .ifu_rdata   (rdata[IFU]),
    .ifu_rresp   (rresp[IFU]),
    .ifu_rvalid  (rvalid[IFU]),
    .ifu_rready  (rready[IFU]),
    .lsu_araddr  (araddr[LSU]),
    .lsu_arvalid (arvalid[LSU]),
    .lsu_arready (arready[LSU]),
    .lsu_rdata   (rdata[LSU]),
    .lsu_rresp   (rresp[LSU]),
    .lsu_rvalid  (rvalid[LSU]),
    .lsu_rready  (rready[LSU]),
    .lsu_awaddr  (awaddr),
    .lsu_awvalid (awvalid),
    .lsu_awready (awready),
    .lsu_wdata   (wdata),
    .lsu_wstrb   (wstrb),
    .lsu_wvalid  (wvalid),
    .lsu_wready  (wready),
    .lsu_bresp   (bresp),
    .lsu_bvalid  (bvalid),
    .lsu_bready  (bready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // cycle count, timeout and response counters.
  always @(posedge clk) begin
    cycles   <= cycles + 1;
    rvalid_q <= rvalid;
    bvalid_q <= bvalid;
    // each response raises its valid once.
    r_seen <= r_seen + int'(rvalid[IFU] && !rvalid_q[IFU]) +
              int'(rvalid[LSU] && !rvalid_q[LSU]);
    b_seen <= b_seen + int'(bvalid && !bvalid_q);
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles, a handshake never completed", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ====================================================================
  // helpers
  // ====================================================================
  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic void check_val(input string name, input logic [31:0] got,
                                    input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endfunction

  function automatic logic [31:0] model_word(input logic [31:0] addr);
    logic [`MEM_DEPTH_LOG2-1:0] w;
    w = addr[`MEM_DEPTH_LOG2+1:2];
    return {model[{w, 2'd3}], model[{w, 2'd2}], model[{w, 2'd1}], model[{w, 2'd0}]};
  endfunction

  function automatic void model_write(input logic [31:0] addr, input logic [31:0] data,
                                      input logic [3:0] strb);
    for (int i = 0; i < 4; i++) begin
      if (strb[i[1:0]]) begin
        model[{addr[`MEM_DEPTH_LOG2+1:2], i[1:0]}] = 8'(data >> (8 * i));
      end
    end
  endfunction

  task automatic do_read(input bit p, input logic [31:0] addr, input int hold,
                         output logic [31:0] data, output logic resp);
    araddr[p]  <= addr;
    arvalid[p] <= 1'b1;
    do @(posedge clk); while (!arready[p]);
    arvalid[p] <= 1'b0;
    repeat (hold) @(posedge clk);
    rready[p] <= 1'b1;
    do @(posedge clk); while (!rvalid[p]);
    rready[p] <= 1'b0;
    data = rdata[p];
    resp = rresp[p];
    r_at[p] = cycles;
    reads_issued++;
  endtask

  task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, input int hold, output logic resp);
    bit aw_done;
    bit w_done;
    aw_done = 1'b0;
    w_done  = 1'b0;
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    wvalid  <= 1'b1;
    while (!(aw_done && w_done)) begin
      @(posedge clk);
      if (!aw_done && awready) begin
        aw_done = 1'b1;
        awvalid <= 1'b0;
      end
      if (!w_done && wready) begin
        w_done = 1'b1;
        wvalid <= 1'b0;
      end
    end
    repeat (hold) @(posedge clk);
    bready <= 1'b1;
    do @(posedge clk); while (!bvalid);
    bready <= 1'b0;
    resp = bresp;
    writes_issued++;
  endtask

  task automatic write_check(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int hold);
    logic           resp;
    mem_pkg::resp_e exp_resp;
    exp_resp = (addr >= MEM_BYTES) ? mem_pkg::RESP_SLVERR : mem_pkg::RESP_OKAY;
    do_write(addr, data, strb, hold, resp);
    check_val("lsu_bresp", 32'(resp), 32'(exp_resp));
    if (exp_resp == mem_pkg::RESP_OKAY) begin
      model_write(addr, data, strb);
    end
  endtask

  task automatic read_check(input bit p, input logic [31:0] addr, input int hold);
    logic [31:0]    data;
    logic           resp;
    mem_pkg::resp_e exp_resp;
    string          who;
    who = p ? "lsu" : "ifu";
    exp_resp = (addr >= MEM_BYTES) ? mem_pkg::RESP_SLVERR : mem_pkg::RESP_OKAY;
    do_read(p, addr, hold, data, resp);
    check_val({who, "_rresp"}, 32'(resp), 32'(exp_resp));
    check_val({who, "_rdata"}, data,
              (exp_resp == mem_pkg::RESP_OKAY) ? model_word(addr) : 32'd0);
  endtask

  task automatic end_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("%s: ok", name);
    end else begin
      tests_bad++;
      $display("%s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  // ====================================================================
  // directed tests
  // ====================================================================
  task automatic test_reset_state();
    check_val("ifu_arready", 32'(arready[IFU]), 32'd1);
    check_val("lsu_arready", 32'(arready[LSU]), 32'd1);
    check_val("lsu_awready", 32'(awready), 32'd1);
    check_val("lsu_wready", 32'(wready), 32'd1);
    check_val("ifu_rvalid", 32'(rvalid[IFU]), 32'd0);
    check_val("lsu_rvalid", 32'(rvalid[LSU]), 32'd0);
    check_val("lsu_bvalid", 32'(bvalid), 32'd0);
  endtask

  task automatic test_strobes();
    for (int k = 0; k < 4; k++) begin
      write_check(32'(4 * k), xorshift32(), 4'hF, 0);
    end
    write_check(32'h4, 32'h1122_3344, 4'b0001, 0);
    write_check(32'h8, 32'h5566_7788, 4'b0110, 1);
    write_check(32'hC, 32'h99AA_BBCC, 4'b1000, 2);
    for (int k = 0; k < 4; k++) begin
      read_check(LSU, 32'(4 * k), k);
    end
  endtask

  task automatic test_shared();
    for (int k = 0; k < 4; k++) begin
      write_check(32'h300 + 32'(4 * k), xorshift32(), 4'hF, 0);
    end
    for (int k = 0; k < 4; k++) begin
      read_check(IFU, 32'h300 + 32'(4 * k), 1);
    end
  endtask

  task automatic test_out_of_range();
    write_check(32'h0, 32'hCAFE_F00D, 4'hF, 0);
    write_check(32'h1000, 32'hDEAD_BEEF, 4'hF, 0);  // would alias word 0.
    read_check(LSU, 32'h1000, 0);
    read_check(IFU, 32'h1FFC, 1);
    read_check(LSU, 32'hFFFF_FFFC, 0);
    read_check(LSU, 32'h0, 0);
  endtask

  task automatic test_contention();
    bit          first;
    bit          prev_first;
    logic [31:0] base;
    for (int k = 0; k < 10; k++) begin
      write_check(32'h200 + 32'(4 * k), xorshift32(), 4'hF, 0);
    end
    prev_first = LSU;
    for (int k = 0; k < 5; k++) begin
      base = 32'h200 + 32'(8 * k);
      fork
        read_check(IFU, base, 0);
        read_check(LSU, base + 32'd4, 0);
      join
      first = (r_at[IFU] < r_at[LSU]) ? IFU : LSU;
      if (k > 0) begin
        check_val("first grant", 32'(first), 32'(!prev_first));
      end
      prev_first = first;
    end
  endtask

  task automatic test_random();
    logic [31:0] r;
    logic [31:0] addr;
    for (int k = 0; k < 32; k++) begin
      write_check(32'h100 + 32'(4 * k), xorshift32(), 4'hF, 0);
    end
    for (int n = 0; n < 200; n++) begin
      r = xorshift32();
      addr = 32'h100 | {25'd0, r[6:2], 2'b00};
      if (r[0]) begin
        write_check(addr, xorshift32(), r[11:8], int'(r[13:12]));
      end else begin
        read_check(r[1], addr, int'(r[13:12]));
      end
    end
    @(posedge clk);
    check_val("read responses", 32'(r_seen), 32'(reads_issued));
    check_val("write responses", 32'(b_seen), 32'(writes_issued));
  endtask

  // ====================================================================
  // main sequence
  // ====================================================================
  initial begin
    int e0;
    rng_state = SEED;
    rst     <= 1'b1;
    araddr  <= '0;
    arvalid <= '0;
    rready  <= '0;
    awaddr  <= '0;
    awvalid <= 1'b0;
    wdata   <= '0;
    wstrb   <= '0;
    wvalid  <= 1'b0;
    bready  <= 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    e0 = errors;
    test_reset_state();
    end_test("reset state", e0);
    e0 = errors;
    test_strobes();
    end_test("strobed writes", e0);
    e0 = errors;
    test_shared();
    end_test("shared memory", e0);
    e0 = errors;
    test_out_of_range();
    end_test("out of range", e0);
    e0 = errors;
    test_contention();
    end_test("contention", e0);
    e0 = errors;
    test_random();
    end_test("random traffic", e0);

    $display("%0d of %0d tests ok, %0d checks, %0d errors",
             tests_run - tests_bad, tests_run, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+include
design/mem_pkg.sv
design/axi_lite_if.sv
design/delay_lfsr.sv
design/axi_sram.sv
design/axi_arbiter.sv
design/mem_subsys.sv
test/mem_subsys_props.sv
test/mem_subsys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module mem_subsys_tb \
  -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/Vmem_subsys_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
  exit 0
fi
exit 1
